// File: esc_code_pkg.sv
// escape word format shared by the embedder and the extractor
// an escape word carries the marker in its top bits and the tlast / tkeep
// sideband of the following data word in its low bits
// import with a wildcard in the module header where the format is needed

`default_nettype none

package esc_code_pkg;

  // --------------------
  // marker
  // --------------------

  // width of the marker field at the top of a word
  localparam int esc_word_w = 32;

  // marker value, also the pattern that forces an escape on plain data
  localparam logic [esc_word_w-1:0] esc_word = 32'hDEADBEEF;

  // --------------------
  // field positions
  // --------------------

  // tlast sits in bit 0 of an escape word
  localparam int esc_last_bit = 0;

  // tkeep field starts right above tlast
  // its width is the keep width of the stream, so it is not fixed here
  localparam int esc_keep_lsb = 1;

  // bits between the tkeep field and the marker stay zero

  // --------------------
  // helpers
  // --------------------

  // compare the top bits of a word against the marker
  // the embedder uses it to decide on an escape for data that looks like a marker
  // the extractor uses it to spot escape words in idle state
  function automatic logic esc_hit(input logic [esc_word_w-1:0] top_bits);
    return top_bits == esc_word;
  endfunction

endpackage : esc_code_pkg

`default_nettype wire

// File: stream_beat_pkg.sv
// default stream geometry and the beat word type
// the top level sets its parameters from these and hands beat_word_t
// to the FIFO as its payload type

`default_nettype none

package stream_beat_pkg;

  // --------------------
  // widths
  // --------------------

  // data width of the stream and of the storage path
  localparam int data_w_default = 64;

  // one keep bit per byte
  localparam int keep_w_default = data_w_default / 8;

  // --------------------
  // storage
  // --------------------

  // FIFO depth in words, escape words included
  localparam int fifo_depth_default = 16;

  // --------------------
  // payload
  // --------------------

  // one word of the folded stream, either data or an escape word
  // there is no sideband here, tlast and tkeep live inside escape words
  typedef logic [data_w_default-1:0] beat_word_t;

endpackage : stream_beat_pkg

`default_nettype wire

// File: tlast_tkeep_embed.sv
// folds tlast and tkeep of an AXI-Stream into the data stream
// a beat with tlast high, or whose top bits match the marker, is sent as
// an escape word followed by the original data, all other beats pass as is
// tkeep is only kept on last beats and sent as zero otherwise

`default_nettype none

module tlast_tkeep_embed
  import esc_code_pkg::*;
  import stream_beat_pkg::*;
#(
  parameter int DATA_W = data_w_default,
  parameter int KEEP_W = keep_w_default
) (
  input  wire               clk,
  input  wire               rst,
  // input stream with sideband
  input  wire  [DATA_W-1:0] i_tdata,
  input  wire  [KEEP_W-1:0] i_tkeep,
  input  wire               i_tlast,
  input  wire               i_tvalid,
  output logic              o_tready,
  // folded word stream
  output logic [DATA_W-1:0] o_word,
  output logic              o_word_valid,
  input  wire               i_word_ready
);

  // --------------------
  // width check
  // --------------------

  // marker, tkeep and tlast all have to fit into one word
  if (DATA_W < esc_word_w + KEEP_W + 1) begin : g_width_check
    $error("DATA_W too small for marker, tkeep and tlast");
  end

  // --------------------
  // FSM
  // --------------------

  // idle: looking at a fresh beat
  // data: escape word went out, data word of the same beat is next
  typedef enum logic {
    st_idle,
    st_data
  } state_t;

  state_t state;
  state_t state_nxt;

  // high while the escape word is on the output
  logic sel_esc;
  // current beat has to be escaped
  logic need_esc;
  // escape word built from the current beat
  logic [DATA_W-1:0] esc_out;

  assign need_esc = i_tlast || esc_hit(i_tdata[DATA_W-1 -: esc_word_w]);

  always_comb begin
    state_nxt = state;
    sel_esc   = 1'b0;
    case (state)
      st_idle: begin
        if (i_tvalid && need_esc) begin
          sel_esc   = 1'b1;
          state_nxt = st_data;
        end
      end
      st_data: begin
        // beat is still held since input ready stayed low
        if (i_tvalid) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // only move on when the word on the output is taken
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else if (i_word_ready) begin
      state <= state_nxt;
    end
  end

  // --------------------
  // output mux
  // --------------------

  always_comb begin
    esc_out                          = '0;
    esc_out[DATA_W-1 -: esc_word_w]  = esc_word;
    // tkeep has no meaning without tlast
    esc_out[esc_keep_lsb +: KEEP_W]  = i_tlast ? i_tkeep : '0;
    esc_out[esc_last_bit]            = i_tlast;
  end

  assign o_word       = sel_esc ? esc_out : i_tdata;
  assign o_word_valid = i_tvalid;
  // the beat is consumed by its data word, never by the escape word
  assign o_tready     = sel_esc ? 1'b0 : i_word_ready;

endmodule : tlast_tkeep_embed

`default_nettype wire

// File: beat_fifo.sv
// synchronous FIFO for one word type with valid / ready on both ports
// payload type and depth come from the parent
// a word written on one edge is readable right after it

`default_nettype none

module beat_fifo
  import stream_beat_pkg::*;
#(
  parameter type T_PAYLOAD = beat_word_t,
  parameter int  DEPTH     = fifo_depth_default
) (
  input  wire      clk,
  input  wire      rst,
  // write side
  input  wire      T_PAYLOAD i_wr_data,
  input  wire      i_wr_valid,
  output logic     o_wr_ready,
  // read side
  output T_PAYLOAD o_rd_data,
  output logic     o_rd_valid,
  input  wire      i_rd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // --------------------
  // storage and pointers
  // --------------------

  T_PAYLOAD mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // number of words held
  logic [CNT_W-1:0] count;

  logic full;
  logic do_wr;
  logic do_rd;

  // step a pointer around the ring, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // --------------------
  // handshakes
  // --------------------

  assign full       = (count == CNT_W'(DEPTH));
  assign o_rd_valid = (count != '0);
  assign do_rd      = o_rd_valid && i_rd_ready;
  // when full a write still goes in if a word leaves in the same cycle
  assign o_wr_ready = !full || do_rd;
  assign do_wr      = i_wr_valid && o_wr_ready;

  assign o_rd_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : beat_fifo

`default_nettype wire

// File: tlast_tkeep_extract.sv
// restores tlast and tkeep from a folded word stream
// an escape word is swallowed and its fields are kept in a register, the
// word after it leaves with those fields, all other words leave with
// tlast and tkeep at zero

`default_nettype none

module tlast_tkeep_extract
  import esc_code_pkg::*;
  import stream_beat_pkg::*;
#(
  parameter int DATA_W = data_w_default,
  parameter int KEEP_W = keep_w_default
) (
  input  wire               clk,
  input  wire               rst,
  // folded word stream
  input  wire  [DATA_W-1:0] i_word,
  input  wire               i_word_valid,
  output logic              o_word_ready,
  // output stream with sideband
  output logic [DATA_W-1:0] o_tdata,
  output logic [KEEP_W-1:0] o_tkeep,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  wire               i_tready
);

  // --------------------
  // width check
  // --------------------

  // same rule as on the embedding side
  if (DATA_W < esc_word_w + KEEP_W + 1) begin : g_width_check
    $error("DATA_W too small for marker, tkeep and tlast");
  end

  // --------------------
  // FSM
  // --------------------

  // idle: next word may be an escape word
  // data: escape seen, next word is data no matter what it looks like
  typedef enum logic {
    st_idle,
    st_data
  } state_t;

  state_t state;
  state_t state_nxt;

  // top bits of the current word match the marker
  logic at_marker;
  // escape word is being consumed this cycle
  logic take_esc;

  // sideband from the last escape word
  logic              last_q;
  logic [KEEP_W-1:0] keep_q;

  assign at_marker = esc_hit(i_word[DATA_W-1 -: esc_word_w]);

  always_comb begin
    state_nxt = state;
    take_esc  = 1'b0;
    case (state)
      st_idle: begin
        // escape words never wait on the output side
        if (i_word_valid && at_marker) begin
          take_esc  = 1'b1;
          state_nxt = st_data;
        end
      end
      st_data: begin
        // leave once the tagged data word is out
        if (i_word_valid && i_tready) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // grab the fields while the escape word is accepted
  always_ff @(posedge clk) begin
    if (take_esc) begin
      last_q <= i_word[esc_last_bit];
      keep_q <= i_word[esc_keep_lsb +: KEEP_W];
    end
  end

  // --------------------
  // outputs
  // --------------------

  // words pass straight through, only valid and ready differ for escapes
  assign o_tdata      = i_word;
  assign o_tvalid     = take_esc ? 1'b0 : i_word_valid;
  assign o_word_ready = take_esc ? 1'b1 : i_tready;

  // stored fields apply to the one word after the escape
  assign o_tlast      = (state == st_data) ? last_q : 1'b0;
  assign o_tkeep      = (state == st_data) ? keep_q : '0;

endmodule : tlast_tkeep_extract

`default_nettype wire

// File: embed_fifo_link.sv
// AXI-Stream link through a data-only FIFO
// embedder folds tlast / tkeep into the words, the FIFO stores the words,
// the extractor restores the sideband on the far side
// latency varies with escapes and back-pressure, o_tvalid marks output

`default_nettype none

module embed_fifo_link
  import stream_beat_pkg::*;
#(
  parameter int DATA_W = data_w_default,
  parameter int KEEP_W = keep_w_default,
  parameter int DEPTH  = fifo_depth_default
) (
  input  wire               clk,
  input  wire               rst,
  // input stream
  input  wire  [DATA_W-1:0] i_tdata,
  input  wire  [KEEP_W-1:0] i_tkeep,
  input  wire               i_tlast,
  input  wire               i_tvalid,
  output logic              o_tready,
  // output stream
  output logic [DATA_W-1:0] o_tdata,
  output logic [KEEP_W-1:0] o_tkeep,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  wire               i_out_tready
);

  // FIFO payload type is fixed by the package, the data width must agree
  if (DATA_W != $bits(beat_word_t)) begin : g_width_check
    $error("DATA_W does not match the FIFO word width");
  end

  // --------------------
  // embedder to FIFO
  // --------------------

  logic [DATA_W-1:0] emb_word;
  logic              emb_word_valid;
  logic              fifo_wr_ready;

  // --------------------
  // FIFO to extractor
  // --------------------

  logic [DATA_W-1:0] fifo_rd_data;
  logic              fifo_rd_valid;
  logic              ext_word_ready;

  tlast_tkeep_embed #(
    .DATA_W (DATA_W),
    .KEEP_W (KEEP_W)
  ) u_embed (
    .clk          (clk),
    .rst          (rst),
    .i_tdata      (i_tdata),
    .i_tkeep      (i_tkeep),
    .i_tlast      (i_tlast),
    .i_tvalid     (i_tvalid),
    .o_tready     (o_tready),
    .o_word       (emb_word),
    .o_word_valid (emb_word_valid),
    .i_word_ready (fifo_wr_ready)
  );

  beat_fifo #(
    .T_PAYLOAD (beat_word_t),
    .DEPTH     (DEPTH)
  ) u_fifo (
    .clk        (clk),
    .rst        (rst),
    .i_wr_data  (emb_word),
    .i_wr_valid (emb_word_valid),
    .o_wr_ready (fifo_wr_ready),
    .o_rd_data  (fifo_rd_data),
    .o_rd_valid (fifo_rd_valid),
    .i_rd_ready (ext_word_ready)
  );

  tlast_tkeep_extract #(
    .DATA_W (DATA_W),
    .KEEP_W (KEEP_W)
  ) u_extract (
    .clk          (clk),
    .rst          (rst),
    .i_word       (fifo_rd_data),
    .i_word_valid (fifo_rd_valid),
    .o_word_ready (ext_word_ready),
    .o_tdata      (o_tdata),
    .o_tkeep      (o_tkeep),
    .o_tlast      (o_tlast),
    .o_tvalid     (o_tvalid),
    .i_tready     (i_out_tready)
  );

endmodule : embed_fifo_link

`default_nettype wire

// File: embed_fifo_link_asserts.sv
// concurrent handshake checks on the ports of embed_fifo_link
// attached to every instance of it by the bind at the end of this file

`default_nettype none

module embed_fifo_link_asserts
  import stream_beat_pkg::*;
#(
  parameter int DATA_W = data_w_default,
  parameter int KEEP_W = keep_w_default
) (
  input wire              clk,
  input wire              rst,
  input wire [DATA_W-1:0] i_in_tdata,
  input wire [KEEP_W-1:0] i_in_tkeep,
  input wire              i_in_tlast,
  input wire              i_in_tvalid,
  input wire              i_in_tready,
  input wire [DATA_W-1:0] i_out_tdata,
  input wire [KEEP_W-1:0] i_out_tkeep,
  input wire              i_out_tlast,
  input wire              i_out_tvalid,
  input wire              i_out_tready
);

  // number of failed checks, read by the testbench
  int unsigned fail_count = 0;

  // --------------------
  // valid holds until ready
  // --------------------

  in_hold: assert property (@(posedge clk) disable iff (rst)
    i_in_tvalid && !i_in_tready |=>
      i_in_tvalid && $stable({i_in_tdata, i_in_tkeep, i_in_tlast}))
  else begin
    $error("input beat dropped or changed before acceptance");
    fail_count++;
  end

  out_hold: assert property (@(posedge clk) disable iff (rst)
    i_out_tvalid && !i_out_tready |=>
      i_out_tvalid && $stable({i_out_tdata, i_out_tkeep, i_out_tlast}))
  else begin
    $error("output beat dropped or changed before acceptance");
    fail_count++;
  end

  // FIFO is empty right after reset
  out_idle: assert property (@(posedge clk) rst |=> !i_out_tvalid)
  else begin
    $error("o_tvalid high in the cycle after reset");
    fail_count++;
  end

endmodule : embed_fifo_link_asserts

bind embed_fifo_link embed_fifo_link_asserts #(
  .DATA_W (DATA_W),
  .KEEP_W (KEEP_W)
) u_asserts (
  .clk          (clk),
  .rst          (rst),
  .i_in_tdata   (i_tdata),
  .i_in_tkeep   (i_tkeep),
  .i_in_tlast   (i_tlast),
  .i_in_tvalid  (i_tvalid),
  .i_in_tready  (o_tready),
  .i_out_tdata  (o_tdata),
  .i_out_tkeep  (o_tkeep),
  .i_out_tlast  (o_tlast),
  .i_out_tvalid (o_tvalid),
  .i_out_tready (i_out_tready)
);

`default_nettype wire

// File: tb_embed_fifo_link.sv
// testbench for embed_fifo_link
// sends random AXI-Stream beats, with last beats and marker-like data mixed in,
// under input gaps and output back-pressure, and checks every output beat
// against a queue of expected beats in order

`default_nettype none

module tb_embed_fifo_link
  import esc_code_pkg::*;
  import stream_beat_pkg::*;
();

  localparam int DATA_W  = data_w_default;
  localparam int KEEP_W  = keep_w_default;
  // expected beat is {data, keep, last}
  localparam int EXP_W   = DATA_W + KEEP_W + 1;
  localparam int TIMEOUT = 1000;

  logic              clk;
  logic              rst;
  logic [DATA_W-1:0] in_tdata;
  logic [KEEP_W-1:0] in_tkeep;
  logic              in_tlast;
  logic              in_tvalid;
  logic              in_tready;
  logic [DATA_W-1:0] out_tdata;
  logic [KEEP_W-1:0] out_tkeep;
  logic              out_tlast;
  logic              out_tvalid;
  logic              out_tready;

  integer seed;
  integer ready_seed;
  // 0 always ready, 1 random, 2 stalled
  int ready_mode = 0;
  int n_out = 0;
  logic [EXP_W-1:0] exp_q[$];

  embed_fifo_link #(
    .DATA_W (DATA_W),
    .KEEP_W (KEEP_W),
    .DEPTH  (fifo_depth_default)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .i_tdata      (in_tdata),
    .i_tkeep      (in_tkeep),
    .i_tlast      (in_tlast),
    .i_tvalid     (in_tvalid),
    .o_tready     (in_tready),
    .o_tdata      (out_tdata),
    .o_tkeep      (out_tkeep),
    .o_tlast      (out_tlast),
    .o_tvalid     (out_tvalid),
    .i_out_tready (out_tready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at the first error");
  endtask

  // reference model where tkeep only survives on a last beat
  function automatic logic [EXP_W-1:0] expected_beat(input logic [DATA_W-1:0] data,
                                                     input logic [KEEP_W-1:0] keep,
                                                     input logic last);
    return {data, last ? keep : {KEEP_W{1'b0}}, last};
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < (DATA_W + 31) / 32; i++) begin
      w = (w << 32) | DATA_W'($unsigned($random(seed)));
    end
    return w;
  endfunction

  // random data that never looks like a marker
  function automatic logic [DATA_W-1:0] plain_word();
    logic [DATA_W-1:0] w;
    w = rand_word();
    if (w[DATA_W-1 -: 32] == esc_word) begin
      w[DATA_W-1] = ~w[DATA_W-1];
    end
    return w;
  endfunction

  function automatic logic [DATA_W-1:0] marker_word();
    logic [DATA_W-1:0] w;
    w = rand_word();
    w[DATA_W-1 -: 32] = esc_word;
    return w;
  endfunction

  function automatic logic [KEEP_W-1:0] rand_keep();
    return KEEP_W'($unsigned($random(seed)));
  endfunction

  // holds the beat until the DUT takes it
  task automatic send_beat(input logic [DATA_W-1:0] data, input logic [KEEP_W-1:0] keep,
                           input logic last);
    int waited;
    @(negedge clk);
    in_tdata  = data;
    in_tkeep  = keep;
    in_tlast  = last;
    in_tvalid = 1'b1;
    exp_q.push_back(expected_beat(data, keep, last));
    waited = 0;
    @(posedge clk);
    while (!in_tready) begin
      waited++;
      if (waited > TIMEOUT) begin
        fail_now("timeout: input beat was not accepted within 1000 cycles");
      end else begin
        @(posedge clk);
      end
    end
  endtask

  task automatic idle_gap(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      in_tvalid = 1'b0;
    end
  endtask

  // plain, last and marker beats in random order with optional gaps
  task automatic send_mixed(input int n, input int gap_pct);
    int kind;
    for (int i = 0; i < n; i++) begin
      kind = $unsigned($random(seed)) % 100;
      if (kind < 60) begin
        send_beat(plain_word(), rand_keep(), 1'b0);
      end else if (kind < 85) begin
        send_beat(plain_word(), rand_keep(), 1'b1);
      end else begin
        send_beat(marker_word(), rand_keep(), 1'($random(seed)));
      end
      if ($unsigned($random(seed)) % 100 < gap_pct) begin
        idle_gap(1 + $unsigned($random(seed)) % 3);
      end
    end
  endtask

  // --------------------
  // output side
  // --------------------

  initial begin
    forever begin
      @(negedge clk);
      case (ready_mode)
        0:       out_tready = 1'b1;
        1:       out_tready = 1'($random(ready_seed));
        default: out_tready = 1'b0;
      endcase
    end
  end

  // compare on every output transfer
  initial begin
    logic [EXP_W-1:0] exp_beat;
    logic [EXP_W-1:0] got_beat;
    forever begin
      @(posedge clk);
      if (!rst && out_tvalid && out_tready) begin
        got_beat = {out_tdata, out_tkeep, out_tlast};
        assert (exp_q.size() > 0)
        else fail_now("output beat appeared while no beat was expected");
        exp_beat = exp_q.pop_front();
        assert (got_beat == exp_beat)
        else fail_now($sformatf(
          "MISMATCH at %0t: beat %0d got %h/%h/%b, expected %h/%h/%b", $time, n_out,
          out_tdata, out_tkeep, out_tlast, exp_beat[EXP_W-1 -: DATA_W],
          exp_beat[KEEP_W:1], exp_beat[0]));
        n_out++;
      end
    end
  end

  // failed bound checks end the run too
  initial begin
    forever begin
      @(negedge clk);
      if (i_dut.u_asserts.fail_count != 0) begin
        fail_now("a handshake assertion on the DUT ports failed");
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------

  initial begin
    int waited;
    seed       = 32'hba53;
    ready_seed = ~seed;
    ready_mode = 0;
    rst        = 1'b1;
    in_tdata   = '0;
    in_tkeep   = '0;
    in_tlast   = 1'b0;
    in_tvalid  = 1'b0;
    out_tready = 1'b1;
    // reset spans three rising edges
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // ordinary beats with tkeep given but tlast low
    for (int i = 0; i < 20; i++) begin
      send_beat(plain_word(), rand_keep(), 1'b0);
    end
    // short packets closed by a last beat
    for (int i = 0; i < 12; i++) begin
      send_beat(plain_word(), rand_keep(), 1'b0);
      send_beat(plain_word(), rand_keep(), 1'b1);
    end
    // marker-like data back to back and with tlast
    for (int i = 0; i < 8; i++) begin
      send_beat(marker_word(), rand_keep(), 1'b0);
      send_beat(marker_word(), rand_keep(), 1'b1);
    end
    // stall the output until the FIFO is full, then random back-pressure
    ready_mode = 2;
    fork
      begin
        repeat (40) @(negedge clk);
        ready_mode = 1;
      end
    join_none
    send_mixed(150, 0);
    // input gaps on top of back-pressure
    send_mixed(150, 30);
    idle_gap(1);
    ready_mode = 0;

    // drain
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) begin
        fail_now("timeout: expected beats never left the DUT");
      end else begin
        @(negedge clk);
      end
    end
    repeat (4) begin
      @(negedge clk);
      assert (!out_tvalid)
      else fail_now("o_tvalid stayed high after the last beat left");
    end

    if (n_out > 0 && i_dut.u_asserts.fail_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      fail_now("end of run reached with failed checks or no output");
    end
  end

endmodule : tb_embed_fifo_link

`default_nettype wire

// File: build.f
esc_code_pkg.sv
stream_beat_pkg.sv
tlast_tkeep_embed.sv
beat_fifo.sv
tlast_tkeep_extract.sv
embed_fifo_link.sv
embed_fifo_link_asserts.sv
tb_embed_fifo_link.sv

// File: Bender.yml
package:
  name: embed_fifo_link

sources:
  - esc_code_pkg.sv
  - stream_beat_pkg.sv
  - tlast_tkeep_embed.sv
  - beat_fifo.sv
  - tlast_tkeep_extract.sv
  - embed_fifo_link.sv
  - target: simulation
    files:
      - embed_fifo_link_asserts.sv
      - tb_embed_fifo_link.sv
